/* verilog/soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Address map with inclusive bases and exclusive tops
`define BRAM_BASE  32'h0000_0000
`define BRAM_TOP   32'h0000_1000
`define PRINT_BASE 32'h1000_0000
`define PRINT_TOP  32'h1000_1000
`define CLINT_BASE 32'h2000_0000
`define CLINT_TOP  32'h2000_C000

// RAM depth in 32-bit words
`define BRAM_WORDS 1024

// Timer register offsets from CLINT_BASE
`define CLINT_MSIP        32'h0000_0000
`define CLINT_MTIMECMP_LO 32'h0000_4000
`define CLINT_MTIMECMP_HI 32'h0000_4004
`define CLINT_MTIME_LO    32'h0000_BFF8
`define CLINT_MTIME_HI    32'h0000_BFFC

`endif

/* verilog/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [63:0] time_t;

  // Which requester a target is currently answering
  typedef enum logic [1:0] {
    owner_none,
    owner_instr,
    owner_data
  } owner_e;

endpackage

`default_nettype wire

/* verilog/bus_decoder.sv */
`default_nettype none

`include "soc_defs.svh"

module bus_decoder (
  input  logic            clk,
  input  logic            rst,
  input  logic            imem_valid_i,
  input  logic            imem_instr_i,
  input  soc_pkg::addr_t  imem_addr_i,
  input  soc_pkg::data_t  imem_wdata_i,
  input  soc_pkg::strb_t  imem_wstrb_i,
  output soc_pkg::data_t  imem_rdata_o,
  output logic            imem_ready_o,
  input  logic            dmem_valid_i,
  input  logic            dmem_instr_i,
  input  soc_pkg::addr_t  dmem_addr_i,
  input  soc_pkg::data_t  dmem_wdata_i,
  input  soc_pkg::strb_t  dmem_wstrb_i,
  output soc_pkg::data_t  dmem_rdata_o,
  output logic            dmem_ready_o,
  output logic            bram_valid_o,
  output logic            bram_instr_o,
  output soc_pkg::addr_t  bram_addr_o,
  output soc_pkg::data_t  bram_wdata_o,
  output soc_pkg::strb_t  bram_wstrb_o,
  input  soc_pkg::data_t  bram_rdata_i,
  input  logic            bram_ready_i,
  output logic            print_valid_o,
  output logic            print_instr_o,
  output soc_pkg::addr_t  print_addr_o,
  output soc_pkg::data_t  print_wdata_o,
  output soc_pkg::strb_t  print_wstrb_o,
  input  soc_pkg::data_t  print_rdata_i,
  input  logic            print_ready_i,
  output logic            clint_valid_o,
  output logic            clint_instr_o,
  output soc_pkg::addr_t  clint_addr_o,
  output soc_pkg::data_t  clint_wdata_o,
  output soc_pkg::strb_t  clint_wstrb_o,
  input  soc_pkg::data_t  clint_rdata_i,
  input  logic            clint_ready_i
);
  import soc_pkg::*;

  localparam int N_TGT   = 3;
  localparam int T_BRAM  = 0;
  localparam int T_PRINT = 1;
  localparam int T_CLINT = 2;

  logic [N_TGT-1:0] i_gnt;
  logic [N_TGT-1:0] d_gnt;
  logic [N_TGT-1:0] fwd_valid;
  logic [N_TGT-1:0] fwd_instr;
  logic [N_TGT-1:0] tgt_ready;
  addr_t            fwd_addr  [N_TGT];
  data_t            fwd_wdata [N_TGT];
  strb_t            fwd_wstrb [N_TGT];
  data_t            tgt_rdata [N_TGT];
  owner_e           owner_q   [N_TGT];
  addr_t            i_addr;
  addr_t            d_addr;

  // One-hot target select in the order timer, print, RAM
  function automatic logic [N_TGT-1:0] decode(input addr_t addr);
    logic [N_TGT-1:0] hit;
    hit = '0;
    if (addr >= `CLINT_BASE && addr < `CLINT_TOP) begin
      hit[T_CLINT] = 1'b1;
    end else if (addr >= `PRINT_BASE && addr < `PRINT_TOP) begin
      hit[T_PRINT] = 1'b1;
    end else if (addr >= `BRAM_BASE && addr < `BRAM_TOP) begin
      hit[T_BRAM] = 1'b1;
    end
    return hit;
  endfunction

  function automatic addr_t base_of(input logic [N_TGT-1:0] hit);
    addr_t base;
    base = `BRAM_BASE;
    if (hit[T_CLINT]) begin
      base = `CLINT_BASE;
    end else if (hit[T_PRINT]) begin
      base = `PRINT_BASE;
    end
    return base;
  endfunction

  // Data port wins a shared target and the losing fetch is dropped
  assign d_gnt  = dmem_valid_i ? decode(dmem_addr_i) : '0;
  assign i_gnt  = (imem_valid_i ? decode(imem_addr_i) : '0) & ~d_gnt;
  assign d_addr = dmem_addr_i - base_of(decode(dmem_addr_i));
  assign i_addr = imem_addr_i - base_of(decode(imem_addr_i));

  for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
    assign fwd_valid[t] = d_gnt[t] | i_gnt[t];
    assign fwd_instr[t] = d_gnt[t] ? dmem_instr_i : imem_instr_i;
    assign fwd_addr[t]  = d_gnt[t] ? d_addr : i_addr;
    assign fwd_wdata[t] = d_gnt[t] ? dmem_wdata_i : imem_wdata_i;
    assign fwd_wstrb[t] = d_gnt[t] ? dmem_wstrb_i : imem_wstrb_i;

    // A new grant takes precedence over a ready clearing the owner
    always_ff @(posedge clk) begin
      if (!rst) begin
        owner_q[t] <= owner_none;
      end else if (d_gnt[t]) begin
        owner_q[t] <= owner_data;
      end else if (i_gnt[t]) begin
        owner_q[t] <= owner_instr;
      end else if (tgt_ready[t]) begin
        owner_q[t] <= owner_none;
      end
    end

    // A target serves one requester at a time
    a_single_grant: assert property (@(posedge clk) disable iff (!rst)
      fwd_valid[t] |-> owner_q[t] == owner_none || tgt_ready[t]);
    a_ready_owned: assert property (@(posedge clk) disable iff (!rst)
      tgt_ready[t] |-> owner_q[t] != owner_none);
  end

  assign bram_valid_o  = fwd_valid[T_BRAM];
  assign bram_instr_o  = fwd_instr[T_BRAM];
  assign bram_addr_o   = fwd_addr[T_BRAM];
  assign bram_wdata_o  = fwd_wdata[T_BRAM];
  assign bram_wstrb_o  = fwd_wstrb[T_BRAM];
  assign print_valid_o = fwd_valid[T_PRINT];
  assign print_instr_o = fwd_instr[T_PRINT];
  assign print_addr_o  = fwd_addr[T_PRINT];
  assign print_wdata_o = fwd_wdata[T_PRINT];
  assign print_wstrb_o = fwd_wstrb[T_PRINT];
  assign clint_valid_o = fwd_valid[T_CLINT];
  assign clint_instr_o = fwd_instr[T_CLINT];
  assign clint_addr_o  = fwd_addr[T_CLINT];
  assign clint_wdata_o = fwd_wdata[T_CLINT];
  assign clint_wstrb_o = fwd_wstrb[T_CLINT];

  assign tgt_ready            = {clint_ready_i, print_ready_i, bram_ready_i};
  assign tgt_rdata[T_BRAM]  = bram_rdata_i;
  assign tgt_rdata[T_PRINT] = print_rdata_i;
  assign tgt_rdata[T_CLINT] = clint_rdata_i;

  // Steer each response by the recorded owner
  always_comb begin
    imem_ready_o = 1'b0;
    imem_rdata_o = '0;
    dmem_ready_o = 1'b0;
    dmem_rdata_o = '0;
    for (int t = 0; t < N_TGT; t++) begin
      if (tgt_ready[t] && owner_q[t] == owner_instr) begin
        imem_ready_o = 1'b1;
        imem_rdata_o = tgt_rdata[t];
      end
      if (tgt_ready[t] && owner_q[t] == owner_data) begin
        dmem_ready_o = 1'b1;
        dmem_rdata_o = tgt_rdata[t];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/bram.sv */
`default_nettype none

`include "soc_defs.svh"

module bram #(
  parameter int DEPTH = `BRAM_WORDS
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           valid_i,
  input  logic           instr_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output soc_pkg::data_t rdata_o,
  output logic           ready_o
);
  import soc_pkg::*;

  localparam int AW = $clog2(DEPTH);

  data_t         mem [DEPTH];
  data_t         rdata_q;
  logic          ready_q;
  logic [AW-1:0] idx;
  logic          wr;

  // Word index ignores the byte offset bits
  assign idx = addr_i[AW+1:2];
  assign wr  = valid_i & ~instr_i & (wstrb_i != '0);

  always_ff @(posedge clk) begin
    if (wr) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (valid_i) begin
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid_i;
    end
  end

  assign rdata_o = rdata_q;
  assign ready_o = ready_q;

  a_in_range: assert property (@(posedge clk) disable iff (!rst)
    valid_i |-> (addr_i >> 2) < DEPTH);

endmodule

`default_nettype wire

/* verilog/print.sv */
`default_nettype none

module print (
  input  logic           clk,
  input  logic           rst,
  input  logic           valid_i,
  input  logic           instr_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output soc_pkg::data_t rdata_o,
  output logic           ready_o,
  output logic           char_valid_o,
  output logic [7:0]     char_o
);

  logic       ready_q;
  logic       char_valid_q;
  logic [7:0] char_q;
  logic       char_wr;

  // Only the word at offset 0 produces a character
  assign char_wr = valid_i & ~instr_i & (wstrb_i != '0) & (addr_i == '0);

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q      <= 1'b0;
      char_valid_q <= 1'b0;
    end else begin
      ready_q      <= valid_i;
      char_valid_q <= char_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (char_wr) begin
      char_q <= wdata_i[7:0];
    end
  end

  assign rdata_o      = '0;
  assign ready_o      = ready_q;
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;

endmodule

`default_nettype wire

/* verilog/clint.sv */
`default_nettype none

`include "soc_defs.svh"

module clint (
  input  logic           clk,
  input  logic           rst,
  input  logic           rtc_i,
  input  logic           valid_i,
  input  logic           instr_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output soc_pkg::data_t rdata_o,
  output logic           ready_o,
  output logic           msip_o,
  output logic           mtip_o,
  output soc_pkg::time_t mtime_o
);
  import soc_pkg::*;

  logic [1:0] rtc_sync;
  logic       rtc_prev;
  logic       rtc_rise;
  time_t      mtime_q;
  time_t      mtimecmp_q;
  logic       msip_q;
  logic       mtip_q;
  logic       ready_q;
  data_t      rdata_q;
  logic       wr;

  function automatic data_t merge(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr       = valid_i & ~instr_i & (wstrb_i != '0);
  assign rtc_rise = rtc_sync[1] & ~rtc_prev;

  // rtc is asynchronous to clk
  always_ff @(posedge clk) begin
    if (!rst) begin
      rtc_sync <= '0;
      rtc_prev <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[0], rtc_i};
      rtc_prev <= rtc_sync[1];
    end
  end

  // Bus writes override the tick
  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      mtip_q     <= 1'b0;
    end else begin
      mtip_q <= mtime_q >= mtimecmp_q;
      if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr) begin
        case (addr_i)
          `CLINT_MSIP: begin
            if (wstrb_i[0]) begin
              msip_q <= wdata_i[0];
            end
          end
          `CLINT_MTIMECMP_LO: mtimecmp_q[31:0]  <= merge(mtimecmp_q[31:0], wdata_i, wstrb_i);
          `CLINT_MTIMECMP_HI: mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], wdata_i, wstrb_i);
          `CLINT_MTIME_LO:    mtime_q[31:0]     <= merge(mtime_q[31:0], wdata_i, wstrb_i);
          `CLINT_MTIME_HI:    mtime_q[63:32]    <= merge(mtime_q[63:32], wdata_i, wstrb_i);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      case (addr_i)
        `CLINT_MSIP:        rdata_q <= {31'b0, msip_q};
        `CLINT_MTIMECMP_LO: rdata_q <= mtimecmp_q[31:0];
        `CLINT_MTIMECMP_HI: rdata_q <= mtimecmp_q[63:32];
        `CLINT_MTIME_LO:    rdata_q <= mtime_q[31:0];
        `CLINT_MTIME_HI:    rdata_q <= mtime_q[63:32];
        default:            rdata_q <= '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid_i;
    end
  end

  assign rdata_o = rdata_q;
  assign ready_o = ready_q;
  assign msip_o  = msip_q;
  assign mtip_o  = mtip_q;
  assign mtime_o = mtime_q;

  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
    ready_q |=> !ready_q);

endmodule

`default_nettype wire

/* verilog/soc_top.sv */
`default_nettype none

module soc_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           rtc_i,
  input  logic           imem_valid_i,
  input  logic           imem_instr_i,
  input  soc_pkg::addr_t imem_addr_i,
  input  soc_pkg::data_t imem_wdata_i,
  input  soc_pkg::strb_t imem_wstrb_i,
  output soc_pkg::data_t imem_rdata_o,
  output logic           imem_ready_o,
  input  logic           dmem_valid_i,
  input  logic           dmem_instr_i,
  input  soc_pkg::addr_t dmem_addr_i,
  input  soc_pkg::data_t dmem_wdata_i,
  input  soc_pkg::strb_t dmem_wstrb_i,
  output soc_pkg::data_t dmem_rdata_o,
  output logic           dmem_ready_o,
  output logic           msip_o,
  output logic           mtip_o,
  output soc_pkg::time_t mtime_o,
  output logic           char_valid_o,
  output logic [7:0]     char_o
);
  import soc_pkg::*;

  logic  bram_valid;
  logic  bram_instr;
  addr_t bram_addr;
  data_t bram_wdata;
  strb_t bram_wstrb;
  data_t bram_rdata;
  logic  bram_ready;
  logic  print_valid;
  logic  print_instr;
  addr_t print_addr;
  data_t print_wdata;
  strb_t print_wstrb;
  data_t print_rdata;
  logic  print_ready;
  logic  clint_valid;
  logic  clint_instr;
  addr_t clint_addr;
  data_t clint_wdata;
  strb_t clint_wstrb;
  data_t clint_rdata;
  logic  clint_ready;

  bus_decoder u_decoder (
    .clk, .rst,
    .imem_valid_i, .imem_instr_i, .imem_addr_i, .imem_wdata_i,
    .imem_wstrb_i, .imem_rdata_o, .imem_ready_o,
    .dmem_valid_i, .dmem_instr_i, .dmem_addr_i, .dmem_wdata_i,
    .dmem_wstrb_i, .dmem_rdata_o, .dmem_ready_o,
    .bram_valid_o(bram_valid), .bram_instr_o(bram_instr), .bram_addr_o(bram_addr),
    .bram_wdata_o(bram_wdata), .bram_wstrb_o(bram_wstrb),
    .bram_rdata_i(bram_rdata), .bram_ready_i(bram_ready),
    .print_valid_o(print_valid), .print_instr_o(print_instr), .print_addr_o(print_addr),
    .print_wdata_o(print_wdata), .print_wstrb_o(print_wstrb),
    .print_rdata_i(print_rdata), .print_ready_i(print_ready),
    .clint_valid_o(clint_valid), .clint_instr_o(clint_instr), .clint_addr_o(clint_addr),
    .clint_wdata_o(clint_wdata), .clint_wstrb_o(clint_wstrb),
    .clint_rdata_i(clint_rdata), .clint_ready_i(clint_ready)
  );

  bram u_bram (
    .clk, .rst,
    .valid_i(bram_valid), .instr_i(bram_instr), .addr_i(bram_addr),
    .wdata_i(bram_wdata), .wstrb_i(bram_wstrb),
    .rdata_o(bram_rdata), .ready_o(bram_ready)
  );

  print u_print (
    .clk, .rst,
    .valid_i(print_valid), .instr_i(print_instr), .addr_i(print_addr),
    .wdata_i(print_wdata), .wstrb_i(print_wstrb),
    .rdata_o(print_rdata), .ready_o(print_ready),
    .char_valid_o, .char_o
  );

  clint u_clint (
    .clk, .rst, .rtc_i,
    .valid_i(clint_valid), .instr_i(clint_instr), .addr_i(clint_addr),
    .wdata_i(clint_wdata), .wstrb_i(clint_wstrb),
    .rdata_o(clint_rdata), .ready_o(clint_ready),
    .msip_o, .mtip_o, .mtime_o
  );

endmodule

`default_nettype wire

/* bench/soc_tb.sv */
`default_nettype none

`include "soc_defs.svh"

module soc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PORT_INSTR = 0;
  localparam int PORT_DATA  = 1;
  localparam int PORT_BOTH  = 2;
  localparam int TIMEOUT    = 4;

  typedef struct {
    int          port;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] rdata;
    bit          resp;
    int          rtc;
    bit          chr;
    bit          msip;
    bit          mtip;
    logic [63:0] mtime;
  } row_t;

  logic        clk;
  logic        rst;
  logic        rtc_i;
  logic        imem_valid_i;
  logic        imem_instr_i;
  logic [31:0] imem_addr_i;
  logic [31:0] imem_wdata_i;
  logic [3:0]  imem_wstrb_i;
  logic [31:0] imem_rdata_o;
  logic        imem_ready_o;
  logic        dmem_valid_i;
  logic        dmem_instr_i;
  logic [31:0] dmem_addr_i;
  logic [31:0] dmem_wdata_i;
  logic [3:0]  dmem_wstrb_i;
  logic [31:0] dmem_rdata_o;
  logic        dmem_ready_o;
  logic        msip_o;
  logic        mtip_o;
  logic [63:0] mtime_o;
  logic        char_valid_o;
  logic [7:0]  char_o;

  // Reference state of the system as seen from the bus
  logic [31:0] ram_model [`BRAM_WORDS];
  logic [63:0] model_mtime;
  logic [63:0] model_cmp;
  bit          model_msip;
  row_t        rows [$];
  integer      seed;

  soc_top u_dut (
    .clk, .rst, .rtc_i,
    .imem_valid_i, .imem_instr_i, .imem_addr_i, .imem_wdata_i,
    .imem_wstrb_i, .imem_rdata_o, .imem_ready_o,
    .dmem_valid_i, .dmem_instr_i, .dmem_addr_i, .dmem_wdata_i,
    .dmem_wstrb_i, .dmem_rdata_o, .dmem_ready_o,
    .msip_o, .mtip_o, .mtime_o, .char_valid_o, .char_o
  );

  always #20 clk = ~clk;

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic bit is_ram(input logic [31:0] addr);
    return addr >= `BRAM_BASE && addr < `BRAM_TOP;
  endfunction

  function automatic bit is_print(input logic [31:0] addr);
    return addr >= `PRINT_BASE && addr < `PRINT_TOP;
  endfunction

  function automatic bit is_clint(input logic [31:0] addr);
    return addr >= `CLINT_BASE && addr < `CLINT_TOP;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = nw[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (is_clint(addr)) begin
      case (addr - `CLINT_BASE)
        `CLINT_MSIP:        return {31'b0, model_msip};
        `CLINT_MTIMECMP_LO: return model_cmp[31:0];
        `CLINT_MTIMECMP_HI: return model_cmp[63:32];
        `CLINT_MTIME_LO:    return model_mtime[31:0];
        `CLINT_MTIME_HI:    return model_mtime[63:32];
        default:            return '0;
      endcase
    end
    if (is_print(addr)) return '0;
    if (is_ram(addr)) return ram_model[(addr - `BRAM_BASE) >> 2];
    return '0;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb);
    if (is_clint(addr)) begin
      case (addr - `CLINT_BASE)
        `CLINT_MSIP:        if (strb[0]) model_msip = wdata[0];
        `CLINT_MTIMECMP_LO: model_cmp[31:0] = merge_bytes(model_cmp[31:0], wdata, strb);
        `CLINT_MTIMECMP_HI: model_cmp[63:32] = merge_bytes(model_cmp[63:32], wdata, strb);
        `CLINT_MTIME_LO:    model_mtime[31:0] = merge_bytes(model_mtime[31:0], wdata, strb);
        `CLINT_MTIME_HI:    model_mtime[63:32] = merge_bytes(model_mtime[63:32], wdata, strb);
        default: ;
      endcase
    end else if (is_ram(addr)) begin
      ram_model[(addr - `BRAM_BASE) >> 2] = merge_bytes(ram_model[(addr - `BRAM_BASE) >> 2],
                                                        wdata, strb);
    end
  endtask

  // Expected values are taken from the model as it stands before the access
  task automatic add_row(input int port, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] strb, input int rtc);
    row_t r;
    model_mtime = model_mtime + rtc;
    r.port  = port;
    r.addr  = addr;
    r.wdata = wdata;
    r.strb  = strb;
    r.rtc   = rtc;
    r.msip  = model_msip;
    r.mtime = model_mtime;
    r.mtip  = model_mtime >= model_cmp;
    r.resp  = is_ram(addr) || is_print(addr) || is_clint(addr);
    r.rdata = model_read(addr);
    r.chr   = port != PORT_INSTR && strb != '0 && addr == `PRINT_BASE;
    if (port != PORT_INSTR && strb != '0) model_write(addr, wdata, strb);
    rows.push_back(r);
  endtask

  task automatic rtc_edges(input int n);
    repeat (n) begin
      rtc_i = 1'b1;
      repeat (4) step();
      rtc_i = 1'b0;
      repeat (4) step();
    end
  endtask

  task automatic apply_row(input row_t r, input int idx);
    bit use_i;
    bit use_d;
    bit exp_i;
    bit exp_d;
    bit watch;
    bit got_i;
    bit got_d;
    int cyc;
    int nchar;
    use_i = r.port != PORT_DATA;
    use_d = r.port != PORT_INSTR;
    // A fetch that collides with the data port never answers
    exp_i = r.port == PORT_INSTR && r.resp;
    exp_d = use_d && r.resp;
    watch = (use_i && !exp_i) || (use_d && !exp_d);
    repeat (2) step();
    rtc_edges(r.rtc);
    check(msip_o, r.msip, "msip_o");
    check(mtip_o, r.mtip, "mtip_o");
    check(mtime_o, r.mtime, "mtime_o");
    if (use_i) begin
      imem_valid_i = 1'b1;
      imem_instr_i = 1'b1;
      imem_addr_i  = r.addr;
      imem_wstrb_i = '0;
    end
    if (use_d) begin
      dmem_valid_i = 1'b1;
      dmem_addr_i  = r.addr;
      dmem_wdata_i = r.wdata;
      dmem_wstrb_i = r.strb;
    end
    cyc   = 0;
    got_i = 1'b0;
    got_d = 1'b0;
    nchar = 0;
    while (cyc < TIMEOUT && ((exp_i && !got_i) || (exp_d && !got_d) || watch)) begin
      step();
      cyc++;
      if (imem_ready_o) begin
        check(exp_i && !got_i, 1'b1, "unexpected instruction ready");
        check(cyc, 1, "instruction ready latency");
        check(imem_rdata_o, r.rdata, "instruction rdata");
        got_i = 1'b1;
      end
      if (dmem_ready_o) begin
        check(exp_d && !got_d, 1'b1, "unexpected data ready");
        check(cyc, 1, "data ready latency");
        if (r.strb == '0) check(dmem_rdata_o, r.rdata, "data rdata");
        got_d = 1'b1;
      end
      if (char_valid_o) begin
        nchar++;
        check(char_o, r.wdata[7:0], "char_o");
      end
      imem_valid_i = 1'b0;
      dmem_valid_i = 1'b0;
    end
    if ((exp_i && !got_i) || (exp_d && !got_d)) begin
      $display("Row %0d: the response never came within %0d cycles", idx, TIMEOUT);
      $display("TEST FAIL");
      $fatal(1, "missing response");
    end
    check(nchar, r.chr, "char_valid_o pulse count");
  endtask

  initial begin
    int cyc;
    clk          = 1'b0;
    rst          = 1'b0;
    rtc_i        = 1'b0;
    imem_valid_i = 1'b0;
    imem_instr_i = 1'b1;
    imem_addr_i  = '0;
    imem_wdata_i = '0;
    imem_wstrb_i = '0;
    dmem_valid_i = 1'b0;
    dmem_instr_i = 1'b0;
    dmem_addr_i  = '0;
    dmem_wdata_i = '0;
    dmem_wstrb_i = '0;
    seed         = 41241;
    model_mtime  = '0;
    model_cmp    = '1;
    model_msip   = 1'b0;

    // RAM with a partial strobe merge and fetches of the same words
    add_row(PORT_DATA,  32'h0000_0100, $random(seed), 4'hF, 0);
    add_row(PORT_DATA,  32'h0000_0100, '0, 4'h0, 0);
    add_row(PORT_DATA,  32'h0000_0100, $random(seed), 4'b0101, 0);
    add_row(PORT_DATA,  32'h0000_0100, '0, 4'h0, 0);
    add_row(PORT_INSTR, 32'h0000_0100, '0, 4'h0, 0);
    add_row(PORT_DATA,  32'h0000_0FFC, $random(seed), 4'hF, 0);
    add_row(PORT_INSTR, 32'h0000_0FFC, '0, 4'h0, 0);
    // Collisions and unmapped addresses
    add_row(PORT_BOTH,  32'h0000_0100, '0, 4'h0, 0);
    add_row(PORT_BOTH,  32'h0000_0200, $random(seed), 4'hF, 0);
    add_row(PORT_DATA,  32'h0000_0200, '0, 4'h0, 0);
    add_row(PORT_DATA,  32'h3000_0000, '0, 4'h0, 0);
    add_row(PORT_INSTR, 32'h0000_1000, '0, 4'h0, 0);
    // Console
    add_row(PORT_DATA,  `PRINT_BASE, $random(seed), 4'hF, 0);
    add_row(PORT_DATA,  `PRINT_BASE, '0, 4'h0, 0);
    add_row(PORT_DATA,  `PRINT_BASE + 32'h4, $random(seed), 4'hF, 0);
    // Timer
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MTIME_LO, '0, 4'h0, 3);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MTIME_HI, '0, 4'h0, 0);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MTIMECMP_HI, '0, 4'hF, 0);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MTIMECMP_LO, model_mtime[31:0] + 32'd2, 4'hF, 0);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MTIMECMP_LO, '0, 4'h0, 0);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MSIP, 32'h1, 4'h1, 0);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MSIP, '0, 4'h0, 0);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MSIP, 32'h0, 4'h1, 0);
    add_row(PORT_DATA,  `CLINT_BASE + `CLINT_MTIME_LO, '0, 4'h0, 1);

    repeat (10) step();
    rst = 1'b1;
    foreach (rows[i]) begin
      apply_row(rows[i], i);
    end

    // The last rtc edge brings mtime up to mtimecmp
    model_mtime = model_mtime + 64'd1;
    rtc_i       = 1'b1;
    cyc = 0;
    while (!mtip_o && cyc < 8) begin
      step();
      cyc++;
    end
    if (!mtip_o) begin
      $display("The timer interrupt never rose after mtime reached mtimecmp");
      $display("TEST FAIL");
      $fatal(1, "missing timer interrupt");
    end else begin
      check(mtime_o, model_mtime, "mtime_o at timer interrupt");
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/bram.sv
verilog/print.sv
verilog/clint.sv
verilog/soc_top.sv
bench/soc_tb.sv

/* Bender.yml */
package:
  name: soc_fabric

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/soc_pkg.sv
      - verilog/bus_decoder.sv
      - verilog/bram.sv
      - verilog/print.sv
      - verilog/clint.sv
      - verilog/soc_top.sv
  - target: simulation
    files:
      - bench/soc_tb.sv
